//--- hdl/sme_pkg.sv
// string match engine definitions

package sme_pkg;

    // ======================================================================
    // sizes
    // ======================================================================
    localparam int STR_LEN = 32;
    localparam int PTN_LEN = 8;

    typedef logic [7:0] char_t;

    // special pattern characters
    localparam char_t CHR_START = 8'h5E;   // ^
    localparam char_t CHR_END   = 8'h24;   // $
    localparam char_t CHR_ANY   = 8'h2E;   // .
    localparam char_t CHR_SPACE = 8'h20;

    // string length 0..32
    typedef logic [5:0] str_len_t;
    // pattern length 0..8
    typedef logic [3:0] ptn_len_t;
    // extended position or alignment offset, 0..33
    typedef logic [5:0] pos_t;

    // ======================================================================
    // images and results
    // ======================================================================

    // chars[0] holds the first character
    typedef struct packed {
        char_t [STR_LEN-1:0] chars;
        str_len_t            len;
    } string_image_t;

    // chars[0] holds pattern element 0
    typedef struct packed {
        char_t [PTN_LEN-1:0] chars;
        ptn_len_t            len;
    } pattern_image_t;

    typedef struct packed {
        logic found;
        pos_t offset;
    } scan_result_t;

endpackage

//--- hdl/sme_string_buffer.sv
// string capture buffer
`timescale 1ns/10ps

module sme_string_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   isstring,
    input  sme_pkg::char_t         chardata,
    output sme_pkg::string_image_t str_image
);
    import sme_pkg::*;

    logic                isstring_d;
    str_len_t            len_q;
    char_t [STR_LEN-1:0] chars_q;

    // delayed strobe marks the first character of a new string
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isstring_d <= 1'b0;
        end else begin
            isstring_d <= isstring;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_q <= '0;
        end else if (isstring) begin
            if (!isstring_d) begin
                len_q <= 6'd1;
            end else begin
                len_q <= len_q + 6'd1;
            end
        end
    end

    // character storage
    always_ff @(posedge clk) begin
        if (isstring) begin
            if (!isstring_d) begin
                chars_q    <= '0;
                chars_q[0] <= chardata;
            end else begin
                chars_q[len_q[4:0]] <= chardata;
            end
        end
    end

    assign str_image = '{chars: chars_q, len: len_q};

    // no more than 32 characters per string
    a_len_limit : assert property (
        @(posedge clk) disable iff (!rst_n)
        (isstring && isstring_d) |=> (len_q <= str_len_t'(STR_LEN))
    );

endmodule

//--- hdl/sme_pattern_buffer.sv
// pattern capture buffer
`timescale 1ns/10ps

module sme_pattern_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ispattern,
    input  logic                    isstring,
    input  sme_pkg::char_t          chardata,
    output sme_pkg::pattern_image_t ptn_image,
    output logic                    pattern_done
);
    import sme_pkg::*;

    logic                ispattern_d;
    ptn_len_t            len_q;
    char_t [PTN_LEN-1:0] chars_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ispattern_d  <= 1'b0;
            pattern_done <= 1'b0;
            len_q        <= '0;
        end else begin
            ispattern_d  <= ispattern;
            // falling edge of ispattern ends the pattern
            pattern_done <= ispattern_d & ~ispattern;
            if (ispattern) begin
                len_q <= ispattern_d ? len_q + 4'd1 : 4'd1;
            end
        end
    end

    // element storage, restarted on the first pattern byte
    always_ff @(posedge clk) begin
        if (ispattern) begin
            if (!ispattern_d) begin
                chars_q    <= '0;
                chars_q[0] <= chardata;
            end else begin
                chars_q[len_q[2:0]] <= chardata;
            end
        end
    end

    assign ptn_image = '{chars: chars_q, len: len_q};

    // string and pattern phases never overlap
    a_no_overlap : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(isstring && ispattern)
    );

endmodule

//--- hdl/sme_window_compare.sv
// single alignment comparator
`timescale 1ns/10ps

module sme_window_compare (
    input  sme_pkg::string_image_t  str_image,
    input  sme_pkg::pattern_image_t ptn_image,
    input  sme_pkg::pos_t           scan_offset,
    output logic                    window_hit
);
    import sme_pkg::*;

    // ======================================================================
    // per element check against the extended string
    // ======================================================================
    always_comb begin
        pos_t  pos;
        char_t elem;
        char_t ch;
        logic  is_start;
        logic  is_real;
        logic  is_end;
        logic  elem_ok;

        window_hit = 1'b1;
        for (int k = 0; k < PTN_LEN; k++) begin
            pos  = scan_offset + pos_t'(k);
            elem = ptn_image.chars[k];
            ch   = str_image.chars[5'(pos - 6'd1)];

            // classify the extended position
            is_start = (pos == 6'd0);
            is_real  = !is_start && (pos <= str_image.len);
            is_end   = (pos == str_image.len + 6'd1);

            case (elem)
                CHR_ANY:   elem_ok = is_real;
                CHR_START: elem_ok = is_start || (is_real && ch == CHR_SPACE);
                CHR_END:   elem_ok = is_end || (is_real && ch == CHR_SPACE);
                default:   elem_ok = is_real && (ch == elem);
            endcase

            // elements past the pattern length always pass
            if (ptn_len_t'(k) < ptn_image.len) begin
                window_hit = window_hit & elem_ok;
            end
        end
    end

endmodule

//--- hdl/sme_scan_control.sv
// search state machine
`timescale 1ns/10ps

module sme_scan_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pattern_done,
    input  sme_pkg::string_image_t str_image,
    input  logic                   window_hit,
    output sme_pkg::pos_t          scan_offset,
    output sme_pkg::scan_result_t  scan_result,
    output logic                   result_strobe
);
    import sme_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SCAN   = 2'd1;
    localparam logic [1:0] ST_REPORT = 2'd2;

    logic [1:0] state;
    pos_t       last_offset;
    logic       scan_stop;

    // last alignment puts element 0 on the end boundary
    assign last_offset = str_image.len + 6'd1;
    assign scan_stop   = window_hit || (scan_offset == last_offset);

    // ======================================================================
    // state and offset
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            scan_offset <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pattern_done) begin
                        state       <= ST_SCAN;
                        scan_offset <= '0;
                    end
                end
                ST_SCAN: begin
                    if (scan_stop) begin
                        state <= ST_REPORT;
                    end else begin
                        scan_offset <= scan_offset + 6'd1;
                    end
                end
                ST_REPORT: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // result captured when the scan stops
    always_ff @(posedge clk) begin
        if (state == ST_SCAN && scan_stop) begin
            scan_result.found  <= window_hit;
            scan_result.offset <= window_hit ? scan_offset : '0;
        end
    end

    // one cycle in report
    assign result_strobe = (state == ST_REPORT);

    a_offset_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ST_SCAN) |-> (scan_offset <= pos_t'(STR_LEN + 1))
    );

endmodule

//--- hdl/sme_result_out.sv
// registered result outputs
`timescale 1ns/10ps

module sme_result_out (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    result_strobe,
    input  sme_pkg::scan_result_t   scan_result,
    input  sme_pkg::pattern_image_t ptn_image,
    output logic                    out_valid,
    output logic                    match,
    output logic [4:0]              match_index
);
    import sme_pkg::*;

    logic anchored;
    pos_t base_index;

    // offset counts from the start boundary, so drop one unless ^ sits there
    assign anchored   = (ptn_image.chars[0] == CHR_START);
    assign base_index = anchored ? scan_result.offset : scan_result.offset - 6'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            match       <= 1'b0;
            match_index <= '0;
        end else if (result_strobe) begin
            out_valid   <= 1'b1;
            match       <= scan_result.found;
            match_index <= scan_result.found ? base_index[4:0] : 5'd0;
        end else begin
            out_valid <= 1'b0;
            // outputs return to zero after the pulse
            if (out_valid) begin
                match       <= 1'b0;
                match_index <= '0;
            end
        end
    end

    a_single_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid
    );

endmodule

//--- hdl/sme_top.sv
// string match engine top
`timescale 1ns/10ps

module sme_top (
    input  logic           clk,
    input  logic           rst_n,
    input  sme_pkg::char_t chardata,
    input  logic           isstring,
    input  logic           ispattern,
    output logic           out_valid,
    output logic           match,
    output logic [4:0]     match_index
);
    import sme_pkg::*;

    string_image_t  str_image;
    pattern_image_t ptn_image;
    logic           pattern_done;
    pos_t           scan_offset;
    logic           window_hit;
    scan_result_t   scan_result;
    logic           result_strobe;

    // ======================================================================
    // input side
    // ======================================================================
    sme_string_buffer i_string_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .isstring  (isstring),
        .chardata  (chardata),
        .str_image (str_image)
    );

    sme_pattern_buffer i_pattern_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .ispattern    (ispattern),
        .isstring     (isstring),
        .chardata     (chardata),
        .ptn_image    (ptn_image),
        .pattern_done (pattern_done)
    );

    // ======================================================================
    // search and output
    // ======================================================================
    sme_scan_control i_scan_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .pattern_done  (pattern_done),
        .str_image     (str_image),
        .window_hit    (window_hit),
        .scan_offset   (scan_offset),
        .scan_result   (scan_result),
        .result_strobe (result_strobe)
    );

    sme_window_compare i_window_compare (
        .str_image   (str_image),
        .ptn_image   (ptn_image),
        .scan_offset (scan_offset),
        .window_hit  (window_hit)
    );

    sme_result_out i_result_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .result_strobe (result_strobe),
        .scan_result   (scan_result),
        .ptn_image     (ptn_image),
        .out_valid     (out_valid),
        .match         (match),
        .match_index   (match_index)
    );

endmodule

//--- testbench/sme_tb.sv
// string match engine testbench
`timescale 1ns/10ps

module sme_tb;

    localparam int CYCLES_PER_VECTOR = 80;
    localparam int RESULT_WAIT       = 40;

    logic       clk;
    logic       rst_n;
    logic [7:0] chardata;
    logic       isstring;
    logic       ispattern;
    logic       out_valid;
    logic       match;
    logic [4:0] match_index;

    string vec_str[$];
    string vec_ptn[$];
    bit    vec_new[$];
    int    vec_match[$];
    int    vec_index[$];
    bit    load_done;
    int    value_errors;
    int    protocol_errors;
    int    pulse_count;

    sme_top i_sme_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .out_valid   (out_valid),
        .match       (match),
        .match_index (match_index)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // vector file
    // ======================================================================
    function automatic int to_int(input string s);
        int v;
        v = 0;
        for (int i = 0; i < s.len(); i++) begin
            v = v * 10 + (s.getc(i) - 8'h30);
        end
        return v;
    endfunction

    // fields are string|pattern|match|index, a dash reuses the last string
    task automatic load_vectors();
        int    fd;
        int    last;
        int    nbar;
        int    bars[3];
        string line;
        string str_field;
        string prev;
        fd = $fopen("testbench/sme_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            protocol_errors++;
            return;
        end
        prev = "";
        while ($fgets(line, fd) > 0) begin
            last = line.len() - 1;
            while (last >= 0 && (line.getc(last) == 8'h0A || line.getc(last) == 8'h0D)) begin
                last--;
            end
            if (last < 0 || line.getc(0) == 8'h23) begin
                continue;
            end
            nbar = 0;
            for (int i = 0; i <= last; i++) begin
                if (line.getc(i) == 8'h7C && nbar < 3) begin
                    bars[nbar] = i;
                    nbar++;
                end
            end
            if (nbar != 3 || bars[0] < 1 || bars[1] <= bars[0] + 1 ||
                bars[2] <= bars[1] + 1 || last <= bars[2]) begin
                $display("malformed line in vector file: %s", line);
                protocol_errors++;
                continue;
            end
            str_field = line.substr(0, bars[0] - 1);
            vec_new.push_back(str_field != "-");
            if (str_field != "-") begin
                prev = str_field;
            end
            vec_str.push_back(prev);
            vec_ptn.push_back(line.substr(bars[0] + 1, bars[1] - 1));
            vec_match.push_back(to_int(line.substr(bars[1] + 1, bars[2] - 1)));
            vec_index.push_back(to_int(line.substr(bars[2] + 1, last)));
        end
        $fclose(fd);
    endtask

    // ======================================================================
    // stimulus and checks
    // ======================================================================
    task automatic send_bytes(input string s, input bit as_pattern);
        for (int i = 0; i < s.len(); i++) begin
            @(negedge clk);
            chardata  = s.getc(i);
            isstring  = !as_pattern;
            ispattern = as_pattern;
        end
    endtask

    task automatic run_vector(input int n);
        int waited;
        repeat ($urandom % 6) @(negedge clk);
        if (vec_new[n]) begin
            send_bytes(vec_str[n], 1'b0);
        end
        send_bytes(vec_ptn[n], 1'b1);
        @(negedge clk);
        isstring  = 1'b0;
        ispattern = 1'b0;
        chardata  = 8'h00;
        waited    = 0;
        while (!out_valid && waited < RESULT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (out_valid) else begin
            $display("no out_valid for vector %0d within %0d cycles", n, RESULT_WAIT);
            protocol_errors++;
        end
        if (out_valid) begin
            assert (match === 1'(vec_match[n])) else begin
                $display("Fail match: got 0x%h, expected 0x%h (vector %0d)",
                         match, 1'(vec_match[n]), n);
                value_errors++;
            end
            assert (match_index === 5'(vec_index[n])) else begin
                $display("Fail match_index: got 0x%h, expected 0x%h (vector %0d)",
                         match_index, 5'(vec_index[n]), n);
                value_errors++;
            end
            @(negedge clk);
            assert (!out_valid) else begin
                $display("out_valid stayed high for more than one cycle (vector %0d)", n);
                protocol_errors++;
            end
        end
    endtask

    // pulse count, and outputs held at zero between pulses
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            pulse_count++;
        end
        if (rst_n && !out_valid) begin
            assert (match === 1'b0 && match_index === 5'd0) else begin
                $display("match or match_index not cleared while out_valid is low");
                protocol_errors++;
            end
        end
    end

    initial begin
        wait (load_done);
        repeat ((vec_str.size() + 1) * CYCLES_PER_VECTOR) @(posedge clk);
        $display("watchdog expired before all vectors completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        chardata        = 8'h00;
        isstring        = 1'b0;
        ispattern       = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        pulse_count     = 0;
        load_done       = 1'b0;
        void'($urandom(32'hc650b8d5));
        load_vectors();
        load_done = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (out_valid === 1'b0 && match === 1'b0 && match_index === 5'd0) else begin
            $display("Fail out_valid/match/match_index after reset: got 0x%h/0x%h/0x%h",
                     out_valid, match, match_index);
            value_errors++;
        end
        assert (vec_str.size() > 0) else begin
            $display("no vectors were loaded");
            protocol_errors++;
        end
        for (int n = 0; n < vec_str.size(); n++) begin
            run_vector(n);
        end
        repeat (4) @(negedge clk);
        assert (pulse_count == vec_str.size()) else begin
            $display("saw %0d out_valid pulses for %0d patterns", pulse_count, vec_str.size());
            protocol_errors++;
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/sme_vectors.txt
# string|pattern|expected match|expected index (decimal)
# a dash as the string searches the previously stored string
hello world|lo w|1|3
-|xyz|0|0
-|o|1|4
abcd|d.|0|0
-|a.c|1|0
-|.a|0|0
the cat sat|^cat|1|4
-|^the|1|0
-|at$|1|5
-|sat$|1|8
-|^s|1|8
-|$|1|3
aaaa|aa|1|0
abcdefghijklmnopqrstuvwxyz012345|yz012345|1|24
-|12345$|1|27
-|^abcdefg|1|0
a b|$b|1|1
x|^x$|1|0

//--- verilog.f
hdl/sme_pkg.sv
hdl/sme_string_buffer.sv
hdl/sme_pattern_buffer.sv
hdl/sme_window_compare.sv
hdl/sme_scan_control.sv
hdl/sme_result_out.sv
hdl/sme_top.sv
testbench/sme_tb.sv

//--- Bender.yml
package:
  name: sme

sources:
  - hdl/sme_pkg.sv
  - hdl/sme_string_buffer.sv
  - hdl/sme_pattern_buffer.sv
  - hdl/sme_window_compare.sv
  - hdl/sme_scan_control.sv
  - hdl/sme_result_out.sv
  - hdl/sme_top.sv
  - target: test
    files:
      - testbench/sme_tb.sv
